// ==== sim.f ====
design/cpu_fetch_pkg.sv
design/cpu_predecode.sv
design/cpu_icache.sv
design/cpu_fetch.sv
design/cpu_fetch_top.sv
tests/tb_bus_memory.sv
tests/tb_cpu_fetch.sv

// ==== tests/tb_cpu_fetch.sv ====
module tb_cpu_fetch;

	timeunit 1ns;
	timeprecision 1ps;

	logic clock;
	logic reset;
	logic jump;
	cpu_fetch_pkg::word_t jump_pc;
	logic irq_pending;
	cpu_fetch_pkg::word_t irq_pc;
	logic irq_dispatched;
	cpu_fetch_pkg::word_t irq_epc;
	logic bus_request;
	logic bus_ready;
	cpu_fetch_pkg::word_t bus_address;
	cpu_fetch_pkg::word_t bus_rdata;
	logic busy;
	cpu_fetch_pkg::fetch_tag_t fetch_tag;
	cpu_fetch_pkg::word_t fetch_instruction;
	cpu_fetch_pkg::word_t fetch_pc;

	// Counters and monitor state
	int errors = 0;
	int presented = 0;
	int dispatches = 0;
	int requests = 0;
	cpu_fetch_pkg::word_t expected_pc;
	cpu_fetch_pkg::word_t last_pc = '0;
	cpu_fetch_pkg::fetch_tag_t last_tag;
	cpu_fetch_pkg::fetch_tag_t next_tag;
	logic busy_before;
	logic request_before;

	logic [31:0] lfsr_state = 32'hb9b3_bbf1;
	int saved_count;
	int saved_requests;
	int guard;
	int busy_len;
	int free_len;

	cpu_fetch_top u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc),
		.o_bus_request(bus_request),
		.i_bus_ready(bus_ready),
		.o_bus_address(bus_address),
		.i_bus_rdata(bus_rdata),
		.i_busy(busy),
		.o_fetch_tag(fetch_tag),
		.o_fetch_instruction(fetch_instruction),
		.o_fetch_pc(fetch_pc)
	);

	tb_bus_memory u_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic int random_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Expected word at an address: JAL, ECALL or ADDI x1, x0, imm
	function automatic cpu_fetch_pkg::word_t expected_word(input cpu_fetch_pkg::word_t address);
		if (address[7:2] == 6'd15) begin
			return 32'h0000_006f;
		end else if (address[7:2] == 6'd31) begin
			return cpu_fetch_pkg::INSN_ECALL;
		end
		return {address[13:2], 5'd0, 3'b000, 5'd1, 7'b001_0011};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task finish_run;
		$display("Words %0d, dispatches %0d, errors %0d", presented, dispatches, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task idle_cycles(input int count);
		repeat (count) @(negedge clock);
	endtask

	task pulse_jump(input cpu_fetch_pkg::word_t target);
		jump = 1'b1;
		jump_pc = target;
		@(negedge clock);
		jump = 1'b0;
	endtask

	// Next presentation of the word at pc_wanted
	task wait_for_word(input cpu_fetch_pkg::word_t pc_wanted, input int limit);
		int start;
		int cycles;
		start = presented;
		cycles = 0;
		while (!(presented > start && last_pc == pc_wanted) && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (!(presented > start && last_pc == pc_wanted)) begin
			$display("Timed out waiting for the word at %h", pc_wanted);
			errors++;
			finish_run();
		end
	endtask

	task wait_for_dispatch(input int total, input int limit);
		int cycles;
		cycles = 0;
		while (dispatches < total && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (dispatches < total) begin
			$display("Timed out waiting for interrupt dispatch number %0d", total);
			errors++;
			finish_run();
		end
	endtask

	// Compare each new tag against the reference stream
	always @(posedge clock) begin
		if (reset) begin
			expected_pc = cpu_fetch_pkg::RESET_VECTOR;
			last_tag = '0;
			busy_before = 1'b0;
			request_before = 1'b0;
		end else begin
			if (fetch_tag != last_tag) begin
				if (busy_before) begin
					$display("A new word was presented while busy was held high");
					errors++;
				end
				next_tag = last_tag + 1'b1;
				check_value("fetch tag", next_tag, fetch_tag);
				check_value("fetch pc", expected_pc, fetch_pc);
				check_value("fetch instruction", expected_word(expected_pc), fetch_instruction);
				last_tag = fetch_tag;
				last_pc = expected_pc;
				presented++;
				expected_pc = expected_pc + 32'd4;
			end
			// Return address is always just past the last presented word
			if (irq_dispatched) begin
				dispatches++;
				check_value("irq epc", last_pc + 32'd4, irq_epc);
				expected_pc = irq_pc;
			end
			if (jump) begin
				expected_pc = jump_pc;
			end
			// A refill always fetches the word that is due next
			if (bus_request && !request_before) begin
				requests++;
				check_value("bus address", expected_pc, bus_address);
			end
			request_before = bus_request;
			busy_before = busy;
		end
	end

	initial begin
		reset = 1'b1;
		jump = 1'b0;
		jump_pc = '0;
		irq_pending = 1'b0;
		irq_pc = 32'h0000_0340;
		busy = 1'b0;
		idle_cycles(3);
		reset = 1'b0;

		// Reset vector up to the JAL at line 15, sweep included
		wait_for_word(32'h0000_013c, 600);
		saved_count = presented;
		idle_cycles(20);
		check_value("words while waiting for jump", saved_count, presented);

		// Replay of cached lines must stay off the bus
		saved_requests = requests;
		pulse_jump(cpu_fetch_pkg::RESET_VECTOR);
		wait_for_word(32'h0000_013c, 200);
		check_value("bus requests on replay", saved_requests, requests);

		// Run into the ECALL and park there
		pulse_jump(32'h0000_0170);
		wait_for_word(32'h0000_017c, 300);
		saved_count = presented;
		idle_cycles(20);
		check_value("words while waiting for irq", saved_count, presented);
		check_value("dispatches before irq", 0, dispatches);
		irq_pending = 1'b1;
		wait_for_dispatch(1, 20);
		check_value("ecall epc", 32'h0000_0180, irq_epc);
		irq_pending = 1'b0;
		wait_for_word(32'h0000_0340, 300);
		check_value("dispatches after ecall", 1, dispatches);

		// Edge in the middle of a straight run
		wait_for_word(32'h0000_034c, 300);
		irq_pc = 32'h0000_0580;
		irq_pending = 1'b1;
		wait_for_dispatch(2, 100);
		wait_for_word(32'h0000_0580, 300);

		// Random busy stretches up to the next JAL, irq line still high
		guard = 0;
		while (last_pc != 32'h0000_063c && guard < 2000) begin
			busy_len = random_bits(3) + 1;
			free_len = random_bits(2) + 1;
			busy = 1'b1;
			idle_cycles(busy_len);
			busy = 1'b0;
			idle_cycles(free_len);
			guard++;
		end
		busy = 1'b0;
		if (last_pc != 32'h0000_063c) begin
			$display("Timed out reaching the JAL at 0000063c under busy stretches");
			errors++;
		end
		check_value("dispatches with irq held high", 2, dispatches);
		irq_pending = 1'b0;
		idle_cycles(4);
		finish_run();
	end

endmodule

// ==== tests/tb_bus_memory.sv ====
module tb_bus_memory (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input cpu_fetch_pkg::word_t i_bus_address,
	output logic o_bus_ready,
	output cpu_fetch_pkg::word_t o_bus_rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	logic ready = 1'b0;
	cpu_fetch_pkg::word_t rdata = '0;
	logic [31:0] lfsr_state = 32'hb9b3_bbf1;
	logic active = 1'b0;
	int remaining = 0;

	assign o_bus_ready = ready;
	assign o_bus_rdata = rdata;

	// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	function automatic int random_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// JAL at line 15, ECALL at line 31, else ADDI x1 with imm from the address
	function automatic cpu_fetch_pkg::word_t instruction_at(input cpu_fetch_pkg::word_t address);
		if (address[7:2] == 6'd15) begin
			return 32'h0000_006f;
		end else if (address[7:2] == 6'd31) begin
			return cpu_fetch_pkg::INSN_ECALL;
		end
		return {address[13:2], 5'd0, 3'b000, 5'd1, 7'b001_0011};
	endfunction

	// Answer each request after 1 to 8 cycles with a one cycle ready pulse
	always @(negedge i_clock) begin
		if (i_reset) begin
			ready <= 1'b0;
			active = 1'b0;
		end else if (ready) begin
			ready <= 1'b0;
		end else if (i_bus_request) begin
			if (!active) begin
				active = 1'b1;
				remaining = random_bits(3) + 1;
			end else begin
				remaining = remaining - 1;
				if (remaining == 0) begin
					ready <= 1'b1;
					rdata <= instruction_at(i_bus_address);
					active = 1'b0;
				end
			end
		end
	end

endmodule

// ==== design/cpu_fetch_top.sv ====
module cpu_fetch_top (
	input logic i_clock,
	input logic i_reset,

	// Execute stage
	input logic i_jump,
	input cpu_fetch_pkg::word_t i_jump_pc,

	// Interrupt controller
	input logic i_irq_pending,
	input cpu_fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output cpu_fetch_pkg::word_t o_irq_epc,

	// Memory bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output cpu_fetch_pkg::word_t o_bus_address,
	input cpu_fetch_pkg::word_t i_bus_rdata,

	// To decode
	input logic i_busy,
	output cpu_fetch_pkg::fetch_tag_t o_fetch_tag,
	output cpu_fetch_pkg::word_t o_fetch_instruction,
	output cpu_fetch_pkg::word_t o_fetch_pc
);

	cpu_fetch u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.i_busy(i_busy),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_instruction(o_fetch_instruction),
		.o_fetch_pc(o_fetch_pc)
	);

endmodule

// ==== design/cpu_fetch.sv ====
module cpu_fetch (
	input logic i_clock,
	input logic i_reset,
	input logic i_jump,
	input cpu_fetch_pkg::word_t i_jump_pc,
	input logic i_irq_pending,
	input cpu_fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output cpu_fetch_pkg::word_t o_irq_epc,
	output logic o_bus_request,
	input logic i_bus_ready,
	output cpu_fetch_pkg::word_t o_bus_address,
	input cpu_fetch_pkg::word_t i_bus_rdata,
	input logic i_busy,
	output cpu_fetch_pkg::fetch_tag_t o_fetch_tag,
	output cpu_fetch_pkg::word_t o_fetch_instruction,
	output cpu_fetch_pkg::word_t o_fetch_pc
);

	cpu_fetch_pkg::fetch_state_t state;
	cpu_fetch_pkg::word_t pc;
	logic last_pending;

	logic icache_ready;
	cpu_fetch_pkg::word_t icache_rdata;
	logic icache_stall;

	logic is_control;
	logic is_trap_wait;

	logic irq_edge;
	logic take_word;
	logic dispatch_normal;
	logic dispatch_wait;

	// Cache only serves while fetch waits on it
	assign icache_stall = i_busy || (state != cpu_fetch_pkg::FETCH_WAIT_ICACHE);

	cpu_icache u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(icache_stall),
		.o_ready(icache_ready),
		.o_rdata(icache_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	cpu_predecode u_predecode (
		.i_instruction(icache_rdata),
		.o_is_control(is_control),
		.o_is_trap_wait(is_trap_wait)
	);

	assign irq_edge = i_irq_pending && !last_pending;
	assign take_word = (state == cpu_fetch_pkg::FETCH_WAIT_ICACHE) && icache_ready;

	// Interrupts only between plain words, never right after a branch
	assign dispatch_normal = take_word && !is_control && !is_trap_wait && irq_edge;
	assign dispatch_wait = (state == cpu_fetch_pkg::FETCH_WAIT_IRQ) && irq_edge;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= cpu_fetch_pkg::FETCH_WAIT_ICACHE;
			pc <= cpu_fetch_pkg::RESET_VECTOR;
			o_fetch_tag <= '0;
			last_pending <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_irq_dispatched <= 1'b0;

			case (state)
				cpu_fetch_pkg::FETCH_WAIT_ICACHE: begin
					if (take_word) begin
						o_fetch_tag <= o_fetch_tag + 1'b1;

						// Advancing the pc starts the next lookup
						pc <= pc + 32'd4;

						if (is_control) begin
							state <= cpu_fetch_pkg::FETCH_WAIT_JUMP;
						end else if (is_trap_wait) begin
							state <= cpu_fetch_pkg::FETCH_WAIT_IRQ;
						end else begin
							last_pending <= i_irq_pending;
							if (dispatch_normal) begin
								o_irq_dispatched <= 1'b1;
								pc <= i_irq_pc;
							end
						end
					end
				end

				cpu_fetch_pkg::FETCH_WAIT_JUMP: begin
					// Execute resolves the target
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= cpu_fetch_pkg::FETCH_WAIT_ICACHE;
					end
				end

				cpu_fetch_pkg::FETCH_WAIT_IRQ: begin
					last_pending <= i_irq_pending;
					if (dispatch_wait) begin
						o_irq_dispatched <= 1'b1;
						pc <= i_irq_pc;
						state <= cpu_fetch_pkg::FETCH_WAIT_ICACHE;
					end
				end

				default: begin
					state <= cpu_fetch_pkg::FETCH_WAIT_ICACHE;
				end
			endcase
		end
	end

	// Presented word and return address
	always_ff @(posedge i_clock) begin
		if (take_word) begin
			o_fetch_instruction <= icache_rdata;
			o_fetch_pc <= pc;
		end

		if (dispatch_normal) begin
			o_irq_epc <= pc + 32'd4;
		end else if (dispatch_wait) begin
			// pc already points past the ECALL/WFI
			o_irq_epc <= pc;
		end
	end

	a_single_dispatch: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
		else $error("interrupt dispatched in two consecutive cycles");

	a_tag_step: assert property (@(posedge i_clock) disable iff (i_reset)
		!$stable(o_fetch_tag) |->
			o_fetch_tag == cpu_fetch_pkg::fetch_tag_t'($past(o_fetch_tag) + 1'b1))
		else $error("fetch tag moved by other than one");

endmodule

// ==== design/cpu_icache.sv ====
module cpu_icache (
	input logic i_clock,
	input logic i_reset,
	input cpu_fetch_pkg::word_t i_pc,
	input logic i_stall,
	output logic o_ready,
	output cpu_fetch_pkg::word_t o_rdata,
	output logic o_bus_request,
	output cpu_fetch_pkg::word_t o_bus_address,
	input logic i_bus_ready,
	input cpu_fetch_pkg::word_t i_bus_rdata
);

	// Line storage
	cpu_fetch_pkg::word_t data_mem [cpu_fetch_pkg::ICACHE_LINES];
	cpu_fetch_pkg::icache_tag_t tag_mem [cpu_fetch_pkg::ICACHE_LINES];
	logic valid_mem [cpu_fetch_pkg::ICACHE_LINES];

	cpu_fetch_pkg::icache_state_t state;
	logic sweeping;
	cpu_fetch_pkg::icache_index_t sweep_index;

	// Registered lookup of the pc
	cpu_fetch_pkg::word_t lookup_pc;
	cpu_fetch_pkg::word_t lookup_data;
	cpu_fetch_pkg::icache_tag_t lookup_tag;
	logic lookup_valid;

	cpu_fetch_pkg::icache_index_t pc_index;
	cpu_fetch_pkg::icache_index_t refill_index;
	cpu_fetch_pkg::icache_tag_t refill_tag;
	logic lookup_current;
	logic lookup_hit;
	logic refill_start;
	logic refill_done;

	assign pc_index = i_pc[7:2];
	assign refill_index = o_bus_address[7:2];
	assign refill_tag = o_bus_address[31:8];

	// Lookup result belongs to the pc fetch is presenting now
	assign lookup_current = (lookup_pc == i_pc) && !sweeping && (state == cpu_fetch_pkg::ICACHE_LOOKUP);
	assign lookup_hit = lookup_valid && (lookup_tag == lookup_pc[31:8]);

	// No new refill is started while stalled
	assign refill_start = lookup_current && !lookup_hit && !i_stall;
	assign refill_done = (state == cpu_fetch_pkg::ICACHE_REFILL) && i_bus_ready;

	assign o_ready = lookup_current && lookup_hit && !i_stall;
	assign o_rdata = lookup_data;
	assign o_bus_request = (state == cpu_fetch_pkg::ICACHE_REFILL);

	// Arrays; the sweep owns the valid bits after reset
	always_ff @(posedge i_clock) begin
		if (sweeping) begin
			valid_mem[sweep_index] <= 1'b0;
		end else if (refill_done) begin
			data_mem[refill_index] <= i_bus_rdata;
			tag_mem[refill_index] <= refill_tag;
			valid_mem[refill_index] <= 1'b1;
		end
	end

	// Lookup payload, bypassed with the bus word at the end of a refill
	always_ff @(posedge i_clock) begin
		if (refill_done) begin
			lookup_pc <= o_bus_address;
			lookup_data <= i_bus_rdata;
			lookup_tag <= refill_tag;
		end else begin
			lookup_pc <= i_pc;
			lookup_data <= data_mem[pc_index];
			lookup_tag <= tag_mem[pc_index];
		end
	end

	// Miss address, held for the whole bus request
	always_ff @(posedge i_clock) begin
		if (state == cpu_fetch_pkg::ICACHE_LOOKUP && refill_start) begin
			o_bus_address <= {i_pc[31:2], 2'b00};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= cpu_fetch_pkg::ICACHE_LOOKUP;
			sweeping <= 1'b1;
			sweep_index <= '0;
			lookup_valid <= 1'b0;
		end else begin
			if (refill_done) begin
				lookup_valid <= 1'b1;
			end else begin
				lookup_valid <= valid_mem[pc_index] && !sweeping;
			end

			// One line per cycle, 64 cycles in all
			if (sweeping) begin
				sweep_index <= sweep_index + 1'b1;
				if (sweep_index == cpu_fetch_pkg::icache_index_t'(cpu_fetch_pkg::ICACHE_LINES - 1)) begin
					sweeping <= 1'b0;
				end
			end

			case (state)
				cpu_fetch_pkg::ICACHE_LOOKUP: begin
					if (refill_start) begin
						state <= cpu_fetch_pkg::ICACHE_REFILL;
					end
				end
				cpu_fetch_pkg::ICACHE_REFILL: begin
					// ready is a single pulse, request drops next cycle
					if (i_bus_ready) begin
						state <= cpu_fetch_pkg::ICACHE_LOOKUP;
					end
				end
				default: begin
					state <= cpu_fetch_pkg::ICACHE_LOOKUP;
				end
			endcase
		end
	end

	a_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address))
		else $error("bus request dropped or address changed before ready");

	// Ready word matches its stored line
	a_ready_line_match: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> valid_mem[pc_index] && (tag_mem[pc_index] == i_pc[31:8])
			&& (data_mem[pc_index] == o_rdata))
		else $error("cache ready with a word that does not match its line");

endmodule

// ==== design/cpu_predecode.sv ====
module cpu_predecode (
	input cpu_fetch_pkg::word_t i_instruction,
	output bit o_is_control,
	output bit o_is_trap_wait
);

	logic [6:0] opcode;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic is_system;
	logic is_mret;
	logic is_ecall;
	logic is_wfi;

	assign opcode = i_instruction[6:0];

	// Opcode classes
	assign is_jal = (opcode == cpu_fetch_pkg::OPC_JAL);
	assign is_jalr = (opcode == cpu_fetch_pkg::OPC_JALR);
	assign is_branch = (opcode == cpu_fetch_pkg::OPC_BRANCH);
	assign is_system = (opcode == cpu_fetch_pkg::OPC_SYSTEM);

	// System words must match in full, funct and register fields included
	assign is_mret = is_system && (i_instruction == cpu_fetch_pkg::INSN_MRET);
	assign is_ecall = is_system && (i_instruction == cpu_fetch_pkg::INSN_ECALL);
	assign is_wfi = is_system && (i_instruction == cpu_fetch_pkg::INSN_WFI);

	// Anything whose successor is decided by execute
	assign o_is_control = is_jal || is_jalr || is_branch || is_mret;

	// Fetch parks until an interrupt edge
	assign o_is_trap_wait = is_ecall || is_wfi;

endmodule

// ==== design/cpu_fetch_pkg.sv ====
package cpu_fetch_pkg;

	// Widths with a meaning of their own
	typedef logic [31:0] word_t;
	typedef logic [7:0] fetch_tag_t;
	typedef logic [5:0] icache_index_t;
	typedef logic [23:0] icache_tag_t;

	// First fetch address after reset
	localparam word_t RESET_VECTOR = 32'h0000_0100;

	// Direct mapped, one word per line, indexed by pc[7:2]
	localparam int ICACHE_LINES = 64;

	// Major opcodes seen by the predecoder
	localparam logic [6:0] OPC_JAL = 7'b110_1111;
	localparam logic [6:0] OPC_JALR = 7'b110_0111;
	localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
	localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

	// Complete system instruction words
	localparam word_t INSN_ECALL = 32'h0000_0073;
	localparam word_t INSN_WFI = 32'h1050_0073;
	localparam word_t INSN_MRET = 32'h3020_0073;

	// Fetch stage FSM
	typedef enum logic [1:0] {
		FETCH_WAIT_ICACHE,
		FETCH_WAIT_JUMP,
		FETCH_WAIT_IRQ
	} fetch_state_t;

	// Cache refill FSM
	typedef enum logic {
		ICACHE_LOOKUP,
		ICACHE_REFILL
	} icache_state_t;

endpackage
